// File: include/axi_mem_defs.svh
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// Byte address width on both address channels
`define AXI_ADDR_WIDTH 13

// Data word width, strobes are one bit per byte
`define AXI_DATA_WIDTH 32

// Byte offset bits below the word address
`define AXI_ADDR_LSB 2

// One less than the 11-bit bus word address
// The memory decodes this many word address bits, giving 1024 words
`define MEM_ADDR_BITS 10

`endif

// File: hw/axi_pkg.sv
package axi_pkg;

	// AXI burst kind as carried on awburst and arburst
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,   // Same address every beat
		BURST_INCR  = 2'b01,   // Address steps by the transfer size
		BURST_WRAP  = 2'b10,   // Steps, then wraps at the block boundary
		BURST_RSVD  = 2'b11
	} axi_burst_e;

	// Response code on bresp and rresp
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

endpackage

// File: hw/mem_pkg.sv
package mem_pkg;

	// What the RAM does in the current cycle
	typedef enum logic [1:0] {
		MEM_IDLE  = 2'b00,
		MEM_READ  = 2'b01,   // Read flag set, word registered at the edge
		MEM_WRITE = 2'b10    // W beat accepted on this edge
	} mem_op_e;

endpackage

// File: hw/mem_access_if.sv
`include "axi_mem_defs.svh"

interface mem_access_if import mem_pkg::*; ();

	logic arv_arr_flag;                      // High for the whole read burst
	logic awv_awr_flag;                      // High for the whole write burst
	logic [`AXI_ADDR_WIDTH-1:0] araddr;      // Current read beat address
	logic [`AXI_ADDR_WIDTH-1:0] awaddr;      // Current write beat address
	logic wready;
	logic wvalid;
	logic rvalid;
	mem_op_e op;

	modport ctrl (
		output arv_arr_flag,
		output awv_awr_flag,
		output araddr,
		output awaddr,
		output wready,
		output wvalid,
		output rvalid,
		output op
	);

	modport mem (
		input arv_arr_flag,
		input awv_awr_flag,
		input araddr,
		input awaddr,
		input wready,
		input wvalid,
		input rvalid,
		input op
	);

endinterface

// File: hw/logic_ram.sv
`include "axi_mem_defs.svh"

module logic_ram (
	input logic s_axi_aclk,
	input logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic [`AXI_DATA_WIDTH-1:0] wdata,
	input logic mem_rden,
	input logic mem_wren,
	input logic [`MEM_ADDR_BITS-1:0] mem_address,
	output logic [`AXI_DATA_WIDTH-1:0] rdata
);

	logic [`AXI_DATA_WIDTH-1:0] ram [0:(1 << `MEM_ADDR_BITS)-1];

	always_ff @(posedge s_axi_aclk) begin
		if (mem_wren) begin
			for (int lane = 0; lane < `AXI_DATA_WIDTH / 8; lane++) begin
				if (wstrb[lane])
					ram[mem_address][lane*8 +: 8] <= wdata[lane*8 +: 8];   // Byte lane
			end
		end
	end

	// Registered read, the word follows the address one edge later
	always_ff @(posedge s_axi_aclk) begin
		if (mem_rden)
			rdata <= ram[mem_address];
	end

	a_rd_wr_excl: assert property (@(posedge s_axi_aclk)
		mem_rden |-> !mem_wren);

endmodule

// File: hw/axi4_logic_ram_wrap.sv
`include "axi_mem_defs.svh"

module axi4_logic_ram_wrap import mem_pkg::*; (
	input logic s_axi_aclk,
	input logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic [`AXI_DATA_WIDTH-1:0] wdata,
	mem_access_if.mem mem,
	output logic [`AXI_DATA_WIDTH-1:0] rdata
);

	logic [`MEM_ADDR_BITS-1:0] mem_address;
	logic mem_rden;
	logic mem_wren;
	logic [`AXI_DATA_WIDTH-1:0] mem_data_out;

	// Read channel owns the RAM address while its flag is up
	assign mem_address = mem.arv_arr_flag ? mem.araddr[`AXI_ADDR_LSB +: `MEM_ADDR_BITS] :
		mem.awv_awr_flag ? mem.awaddr[`AXI_ADDR_LSB +: `MEM_ADDR_BITS] : '0;

	assign mem_wren = mem.wready && mem.wvalid;      // One write per W handshake
	assign mem_rden = mem.arv_arr_flag;

	logic_ram u_logic_ram (
		.s_axi_aclk  (s_axi_aclk),
		.wstrb       (wstrb),
		.wdata       (wdata),
		.mem_rden    (mem_rden),
		.mem_wren    (mem_wren),
		.mem_address (mem_address),
		.rdata       (mem_data_out)
	);

	always_comb begin
		if (mem.rvalid)
			rdata = mem_data_out;
		else
			rdata = '0;                              // Bus sees zero between beats
	end

	a_flags_excl: assert property (@(posedge s_axi_aclk)
		mem.arv_arr_flag |-> !mem.awv_awr_flag);

	// Write enable must agree with what the controller says it is doing
	a_wren_op: assert property (@(posedge s_axi_aclk)
		mem_wren |-> mem.op == MEM_WRITE);

endmodule

// File: hw/axi4_slave_ctrl.sv
`include "axi_mem_defs.svh"

module axi4_slave_ctrl import axi_pkg::*, mem_pkg::*; (
	input logic s_axi_aclk,
	input logic reset,
	input logic [`AXI_ADDR_WIDTH-1:0] awaddr,
	input logic [7:0] awlen,
	input logic [1:0] awburst,
	input logic awvalid,
	input logic wlast,
	input logic wvalid,
	input logic bready,
	input logic [`AXI_ADDR_WIDTH-1:0] araddr,
	input logic [7:0] arlen,
	input logic [1:0] arburst,
	input logic arvalid,
	input logic rready,
	output logic awready,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	output logic arready,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	mem_access_if.ctrl mem
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITE,
		S_WRESP,
		S_READ
	} state_e;

	state_e state;
	logic [7:0] beat_cnt;                       // Read beats already handed over
	logic [7:0] burst_len;                      // Beats minus one, as on the bus
	axi_burst_e burst_kind;
	logic [`AXI_ADDR_WIDTH-1:0] wrap_mask;      // Byte offset bits inside a WRAP block
	logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
	logic [`AXI_ADDR_WIDTH-1:0] rd_addr;
	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic r_hs;

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign ar_hs = arvalid && arready;
	assign r_hs = rvalid && rready;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	// Beat address step for the burst in progress
	function automatic logic [`AXI_ADDR_WIDTH-1:0] next_addr(
		input logic [`AXI_ADDR_WIDTH-1:0] addr
	);
		logic [`AXI_ADDR_WIDTH-1:0] incr;
		incr = addr + `AXI_ADDR_WIDTH'(`AXI_DATA_WIDTH / 8);
		case (burst_kind)
			BURST_INCR: next_addr = incr;
			BURST_WRAP: next_addr = (addr & ~wrap_mask) | (incr & wrap_mask);
			default:    next_addr = addr;     // FIXED and reserved hold
		endcase
	endfunction

	always_ff @(posedge s_axi_aclk) begin
		if (reset) begin
			state <= S_IDLE;
			awready <= 1'b0;
			arready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			beat_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (ar_hs) begin
						arready <= 1'b0;
						beat_cnt <= '0;
						state <= S_READ;
					end else if (aw_hs) begin
						awready <= 1'b0;
						wready <= 1'b1;
						state <= S_WRITE;
					end else if (!arready && !awready) begin
						if (arvalid)
							arready <= 1'b1;    // Read wins a tie
						else if (awvalid)
							awready <= 1'b1;
					end
				end
				S_WRITE: begin
					if (w_hs && wlast) begin
						wready <= 1'b0;
						bvalid <= 1'b1;
						state <= S_WRESP;
					end
				end
				S_WRESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state <= S_IDLE;
					end
				end
				S_READ: begin
					// RAM loads rd_addr on this edge, so data is valid next cycle
					if (!rvalid) begin
						rvalid <= 1'b1;
						rlast <= (beat_cnt == burst_len);
					end else if (rready) begin
						rvalid <= 1'b0;
						rlast <= 1'b0;
						beat_cnt <= beat_cnt + 8'd1;
						if (rlast)
							state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Burst parameters are latched at acceptance, addresses step per beat
	always_ff @(posedge s_axi_aclk) begin
		if (ar_hs) begin
			rd_addr <= araddr;
			burst_len <= arlen;
			burst_kind <= axi_burst_e'(arburst);
			wrap_mask <= `AXI_ADDR_WIDTH'({arlen, 2'b11});
		end else if (aw_hs) begin
			wr_addr <= awaddr;
			burst_len <= awlen;
			burst_kind <= axi_burst_e'(awburst);
			wrap_mask <= `AXI_ADDR_WIDTH'({awlen, 2'b11});
		end
		if (w_hs)
			wr_addr <= next_addr(wr_addr);
		if (r_hs)
			rd_addr <= next_addr(rd_addr);
	end

	assign mem.arv_arr_flag = (state == S_READ);
	assign mem.awv_awr_flag = (state == S_WRITE);
	assign mem.araddr = rd_addr;
	assign mem.awaddr = wr_addr;
	assign mem.wready = wready;
	assign mem.wvalid = wvalid;
	assign mem.rvalid = rvalid;

	always_comb begin
		if (state == S_READ)
			mem.op = MEM_READ;
		else if (w_hs)
			mem.op = MEM_WRITE;
		else
			mem.op = MEM_IDLE;
	end

	a_addr_ready_excl: assert property (@(posedge s_axi_aclk) disable iff (reset)
		!(awready && arready));

	a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (reset)
		bvalid && !bready |=> bvalid);

	// Held beat keeps its flag and the address the RAM keeps reading
	a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rlast) && $stable(mem.araddr));

	a_wready_in_burst: assert property (@(posedge s_axi_aclk) disable iff (reset)
		wready |-> mem.awv_awr_flag);

endmodule

// File: hw/axi4_mem_top.sv
`include "axi_mem_defs.svh"

module axi4_mem_top (
	input logic s_axi_aclk,
	input logic reset,
	input logic [`AXI_ADDR_WIDTH-1:0] awaddr,
	input logic [7:0] awlen,
	input logic [1:0] awburst,
	input logic awvalid,
	output logic awready,
	input logic [`AXI_DATA_WIDTH-1:0] wdata,
	input logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`AXI_ADDR_WIDTH-1:0] araddr,
	input logic [7:0] arlen,
	input logic [1:0] arburst,
	input logic arvalid,
	output logic arready,
	output logic [`AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready
);

	mem_access_if mem_if ();

	axi4_slave_ctrl u_ctrl (
		.s_axi_aclk (s_axi_aclk),
		.reset      (reset),
		.awaddr     (awaddr),
		.awlen      (awlen),
		.awburst    (awburst),
		.awvalid    (awvalid),
		.wlast      (wlast),
		.wvalid     (wvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arlen      (arlen),
		.arburst    (arburst),
		.arvalid    (arvalid),
		.rready     (rready),
		.awready    (awready),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.arready    (arready),
		.rresp      (rresp),
		.rlast      (rlast),
		.rvalid     (rvalid),
		.mem        (mem_if.ctrl)
	);

	// Write data and strobes bypass the controller
	axi4_logic_ram_wrap u_ram_wrap (
		.s_axi_aclk (s_axi_aclk),
		.wstrb      (wstrb),
		.wdata      (wdata),
		.mem        (mem_if.mem),
		.rdata      (rdata)
	);

endmodule

// File: tb/axi4_mem_tb.sv
`include "axi_mem_defs.svh"

module axi4_mem_tb import axi_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;    // Tests need well under half of this

	logic s_axi_aclk;
	logic reset;
	logic [`AXI_ADDR_WIDTH-1:0] awaddr, araddr;
	logic [7:0] awlen, arlen;
	logic [1:0] awburst, arburst, bresp, rresp;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rlast, rvalid, rready;
	logic [`AXI_DATA_WIDTH-1:0] wdata, rdata;
	logic [`AXI_DATA_WIDTH/8-1:0] wstrb;

	logic [`AXI_DATA_WIDTH-1:0] model [0:(1 << `MEM_ADDR_BITS)-1];   // Reference memory
	logic [`AXI_ADDR_WIDTH-1:0] wr_exp_addr, rd_exp_addr;
	logic [`MEM_ADDR_BITS-1:0] wr_word, rd_word;
	logic [7:0] wr_len, rd_len, rd_beat;
	axi_burst_e wr_kind, rd_kind;
	logic [`AXI_DATA_WIDTH-1:0] exp_rdata;
	logic [31:0] lcg_state;
	int cycle_cnt = 0;

	axi4_mem_top DUT (.*);

	initial begin
		s_axi_aclk = 1'b0;
		forever #10 s_axi_aclk = ~s_axi_aclk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Address of the following beat, WRAP returns to the block start
	function automatic logic [`AXI_ADDR_WIDTH-1:0] beat_step(
		input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [7:0] len, input axi_burst_e kind);
		logic [`AXI_ADDR_WIDTH-1:0] block_bytes;
		logic [`AXI_ADDR_WIDTH-1:0] block_base;
		block_bytes = `AXI_ADDR_WIDTH'((len + 1) * 4);
		block_base = addr - (addr % block_bytes);
		case (kind)
			BURST_INCR: return addr + `AXI_ADDR_WIDTH'(4);
			BURST_WRAP: begin
				if (addr + `AXI_ADDR_WIDTH'(4) == block_base + block_bytes)
					return block_base;
				return addr + `AXI_ADDR_WIDTH'(4);
			end
			default: return addr;
		endcase
	endfunction

	function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	task automatic next_cycle();
		@(posedge s_axi_aclk);
		#2;
	endtask

	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first failing check");
	endtask

	task automatic report_value_error(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error: %s expected 0x%h, actual 0x%h", name, expected, actual);
		stop_with_failure();
	endtask

	// Tracks beat addresses and applies accepted write beats to the model
	assign wr_word = wr_exp_addr[`AXI_ADDR_LSB +: `MEM_ADDR_BITS];
	assign rd_word = rd_exp_addr[`AXI_ADDR_LSB +: `MEM_ADDR_BITS];
	assign exp_rdata = model[rd_word];

	always @(posedge s_axi_aclk) begin
		if (awvalid && awready) begin
			wr_exp_addr <= awaddr;
			wr_len <= awlen;
			wr_kind <= axi_burst_e'(awburst);
		end
		if (wvalid && wready) begin
			model[wr_word] <= (model[wr_word] & ~strobe_mask(wstrb)) |
				(wdata & strobe_mask(wstrb));
			wr_exp_addr <= beat_step(wr_exp_addr, wr_len, wr_kind);
		end
		if (arvalid && arready) begin
			rd_exp_addr <= araddr;
			rd_len <= arlen;
			rd_kind <= axi_burst_e'(arburst);
			rd_beat <= 8'd0;
		end
		if (rvalid && rready) begin
			rd_exp_addr <= beat_step(rd_exp_addr, rd_len, rd_kind);
			rd_beat <= rd_beat + 8'd1;
		end
	end

	always @(posedge s_axi_aclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	a_rdata: assert property (@(posedge s_axi_aclk) disable iff (reset)
		rvalid && rready |-> rdata == exp_rdata)
		else report_value_error("rdata", $sampled(exp_rdata), $sampled(rdata));

	a_rlast: assert property (@(posedge s_axi_aclk) disable iff (reset)
		rvalid && rready |-> rlast == (rd_beat == rd_len))
		else report_value_error("rlast", 32'($sampled(rd_beat == rd_len)), 32'($sampled(rlast)));

	a_rresp: assert property (@(posedge s_axi_aclk) disable iff (reset)
		rvalid && rready |-> rresp == RESP_OKAY)
		else report_value_error("rresp", 32'(RESP_OKAY), 32'($sampled(rresp)));

	a_bresp: assert property (@(posedge s_axi_aclk) disable iff (reset)
		bvalid && bready |-> bresp == RESP_OKAY)
		else report_value_error("bresp", 32'(RESP_OKAY), 32'($sampled(bresp)));

	a_r_stall: assert property (@(posedge s_axi_aclk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
		else begin
			$display("Read beat changed while rready was low");
			stop_with_failure();
		end

	a_b_stall: assert property (@(posedge s_axi_aclk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin
			$display("bvalid dropped before bready accepted it");
			stop_with_failure();
		end

	a_reset_idle: assert property (@(posedge s_axi_aclk)
		reset |=> !(awready || wready || bvalid || arready || rvalid))
		else begin
			$display("A ready or valid output was high after reset");
			stop_with_failure();
		end

	task automatic write_burst(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int len,
		input axi_burst_e kind, input logic [3:0] strb, input int bready_delay);
		awaddr = addr;
		awlen = 8'(len);
		awburst = kind;
		awvalid = 1'b1;
		while (!awready)
			next_cycle();
		next_cycle();                                // AW handshake edge
		awvalid = 1'b0;
		wvalid = 1'b1;
		for (int beat = 0; beat <= len; beat++) begin
			wdata = next_random();
			wstrb = strb;
			wlast = (beat == len);
			while (!wready)
				next_cycle();
			next_cycle();
		end
		wvalid = 1'b0;
		wlast = 1'b0;
		while (!bvalid)
			next_cycle();
		repeat (bready_delay)
			next_cycle();
		bready = 1'b1;
		next_cycle();
		bready = 1'b0;
	endtask

	// A negative stall_beat reads without back-pressure
	task automatic read_burst(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int len,
		input axi_burst_e kind, input int stall_beat);
		araddr = addr;
		arlen = 8'(len);
		arburst = kind;
		arvalid = 1'b1;
		while (!arready)
			next_cycle();
		next_cycle();
		arvalid = 1'b0;
		rready = 1'b1;
		for (int beat = 0; beat <= len; beat++) begin
			while (!rvalid)
				next_cycle();
			if (beat == stall_beat) begin
				rready = 1'b0;
				repeat (4)
					next_cycle();
				rready = 1'b1;
			end
			next_cycle();
		end
		rready = 1'b0;
	endtask

	initial begin
		lcg_state = 32'h203c_04db;
		reset = 1'b1;
		awaddr = '0;
		awlen = '0;
		awburst = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arlen = '0;
		arburst = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (8)
			@(posedge s_axi_aclk);
		#2;
		reset = 1'b0;

		write_burst(13'h010, 0, BURST_INCR, 4'b1111, 0);
		read_burst(13'h010, 0, BURST_INCR, -1);

		// Byte lanes merge over a full word
		write_burst(13'h040, 0, BURST_INCR, 4'b1111, 0);
		write_burst(13'h040, 0, BURST_INCR, 4'b0001, 0);
		read_burst(13'h040, 0, BURST_INCR, -1);
		write_burst(13'h040, 0, BURST_INCR, 4'b0110, 0);
		read_burst(13'h040, 0, BURST_INCR, -1);
		write_burst(13'h040, 0, BURST_INCR, 4'b1000, 2);
		read_burst(13'h040, 0, BURST_INCR, -1);

		write_burst(13'h104, 15, BURST_INCR, 4'b1111, 3);
		read_burst(13'h104, 15, BURST_INCR, 7);

		write_burst(13'h208, 3, BURST_WRAP, 4'b1111, 0);   // Offsets 2, 3, 0, 1
		for (int i = 0; i < 4; i++)
			read_burst(13'(13'h200 + 4 * i), 0, BURST_INCR, -1);
		read_burst(13'h208, 3, BURST_WRAP, 2);

		write_burst(13'h300, 2, BURST_FIXED, 4'b1111, 0);
		read_burst(13'h300, 2, BURST_FIXED, 1);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: axi4_mem_top.f
+incdir+include
hw/axi_pkg.sv
hw/mem_pkg.sv
hw/mem_access_if.sv
hw/logic_ram.sv
hw/axi4_logic_ram_wrap.sv
hw/axi4_slave_ctrl.sv
hw/axi4_mem_top.sv
tb/axi4_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AXI memory testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module axi4_mem_tb \
	-Mdir "$BUILD_DIR" -f axi4_mem_top.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vaxi4_mem_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "=== PASS ===" "$LOG_FILE"; then
	exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
